//--- intc_top.f
hw/intc_pkg.sv
hw/intc_bus_if.sv
hw/axil_reg_slave.sv
hw/intc_regs.sv
hw/irq_pending.sv
hw/irq_sequencer.sv
hw/irq_timer.sv
hw/intc_top.sv
test/tb_clk_gen.sv
test/intc_tb.sv

//--- Bender.yml
package:
  name: intc

sources:
  - hw/intc_pkg.sv
  - hw/intc_bus_if.sv
  - hw/axil_reg_slave.sv
  - hw/intc_regs.sv
  - hw/irq_pending.sv
  - hw/irq_sequencer.sv
  - hw/irq_timer.sv
  - hw/intc_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/intc_tb.sv

//--- test/intc_tb.sv
`timescale 1ns/1ps

module intc_tb;
  import intc_pkg::*;

  localparam int N_ITER          = 16;
  localparam int WATCHDOG_CYCLES = N_ITER * 200 + 2000;

  logic                   clk;
  logic                   rst;
  reg_addr_t              awaddr;
  logic                   awvalid;
  logic                   awready;
  word_t                  wdata;
  logic                   wvalid;
  logic                   wready;
  logic [1:0]             bresp;
  logic                   bvalid;
  logic                   bready;
  reg_addr_t              araddr;
  logic                   arvalid;
  logic                   arready;
  word_t                  rdata;
  logic [1:0]             rresp;
  logic                   rvalid;
  logic                   rready;
  logic [NUM_EXT_IRQ-1:0] irq;
  logic                   irq_ack;
  logic                   irq_req;
  word_t                  vec_off;

  int       errors;
  int       checks;
  irq_vec_t m_mask; // reference model of the controller
  irq_vec_t m_pend;
  irq_vec_t m_active;

  tb_clk_gen u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  intc_top UUT (
    .clk_i           (clk),
    .rst_i           (rst),
    .s_awaddr_i      (awaddr),
    .s_awvalid_i     (awvalid),
    .s_awready_o     (awready),
    .s_wdata_i       (wdata),
    .s_wvalid_i      (wvalid),
    .s_wready_o      (wready),
    .s_bresp_o       (bresp),
    .s_bvalid_o      (bvalid),
    .s_bready_i      (bready),
    .s_araddr_i      (araddr),
    .s_arvalid_i     (arvalid),
    .s_arready_o     (arready),
    .s_rdata_o       (rdata),
    .s_rresp_o       (rresp),
    .s_rvalid_o      (rvalid),
    .s_rready_i      (rready),
    .irq_i           (irq),
    .irq_ack_i       (irq_ack),
    .irq_req_o       (irq_req),
    .vector_offset_o (vec_off)
  );

  task automatic expect_word(input string name, input word_t exp, input word_t got);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s exp=%h got=%h", name, exp, got);
      errors++;
    end
  endtask

  // all bus tasks start and end right after a rising edge
  task automatic axi_write(input reg_addr_t addr, input word_t data);
    int unsigned b_delay;
    b_delay = $urandom % 3;
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(posedge clk); while (!awready);
    expect_word("s_wready_o", 1, wready); // W is taken on the same cycle as AW
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    repeat (b_delay) @(posedge clk);
    bready <= 1'b1;
    do @(posedge clk); while (!bvalid);
    bready <= 1'b0;
    expect_word("s_bresp_o", 0, bresp);
  endtask

  task automatic axi_read(input reg_addr_t addr, output word_t data);
    int unsigned r_delay;
    r_delay = $urandom % 3;
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    repeat (r_delay) @(posedge clk);
    rready <= 1'b1;
    do @(posedge clk); while (!rvalid);
    rready <= 1'b0;
    data = rdata;
    expect_word("s_rresp_o", 0, rresp);
  endtask

  task automatic check_reg(input reg_addr_t addr, input word_t exp, input string name);
    word_t got;
    axi_read(addr, got);
    expect_word(name, exp, got);
  endtask

  function automatic irq_vec_t lowest_onehot(input irq_vec_t vec);
    irq_vec_t res;
    res = '0;
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
      if (vec[i]) res = irq_vec_t'(1) << i; // the last hit is the lowest index
    end
    return res;
  endfunction

  function automatic int line_index(input irq_vec_t onehot);
    int idx;
    idx = 0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      if (onehot[i]) idx = i;
    end
    return idx;
  endfunction

  task automatic wait_req(input int limit);
    int n;
    n = 0;
    while (irq_req !== 1'b1 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (irq_req !== 1'b1) begin
      $display("irq_req_o did not rise within %0d cycles", limit);
      errors++;
    end
  endtask

  task automatic service_line();
    m_active = lowest_onehot(m_pend);
    wait_req(10);
    expect_word("vector_offset_o", line_index(m_active) * 4, vec_off);
    check_reg(REG_ACTIVE, m_active, "ACTIVE");
    if ($urandom % 2) begin
      axi_write(REG_CLEAR, $urandom); // clear before the ack is dropped
      check_reg(REG_PENDING, m_pend, "PENDING");
      check_reg(REG_ACTIVE, m_active, "ACTIVE");
    end
    irq_ack <= 1'b1;
    @(posedge clk);
    irq_ack <= 1'b0;
    @(posedge clk);
    expect_word("irq_req_o", 0, irq_req);
    axi_write(REG_CLEAR, $urandom);
    m_pend   = m_pend & ~m_active;
    m_active = lowest_onehot(m_pend); // next line is taken at once when one is left
    check_reg(REG_PENDING, m_pend, "PENDING");
    check_reg(REG_ACTIVE, m_active, "ACTIVE");
  endtask

  task automatic readback_phase();
    word_t     val;
    reg_addr_t addr;
    val = $urandom;
    axi_write(REG_MASK, val);
    m_mask = val[NUM_IRQ-1:0];
    check_reg(REG_MASK, m_mask, "MASK");
    axi_write(REG_MASK, 32'h1f); // timer line stays out of pending while it may run
    m_mask = '1;
    val = $urandom;
    axi_write(REG_TMR_CMP, val);
    check_reg(REG_TMR_CMP, val, "TMR_CMP");
    val = $urandom;
    axi_write(REG_TMR_CTRL, val);
    check_reg(REG_TMR_CTRL, val[0], "TMR_CTRL");
    axi_write(REG_TMR_CTRL, 32'h0);
    do addr = $urandom; while (addr[1:0] == 2'b00 && addr <= REG_TMR_CTRL);
    check_reg(addr, 0, "unmapped read");
  endtask

  task automatic priority_phase();
    word_t                  r;
    logic [NUM_EXT_IRQ-1:0] pulse;
    r      = $urandom;
    m_mask = r[NUM_IRQ-1:0];
    m_mask[TIMER_IRQ] = 1'b1;
    pulse  = $urandom % 15 + 1;
    axi_write(REG_MASK, m_mask);
    irq <= pulse;
    @(posedge clk);
    irq <= '0;
    m_pend = m_pend | ({1'b0, pulse} & ~m_mask);
    axi_write(REG_MASK, 32'h1f); // masking now must not drop pending lines
    m_mask = '1;
    check_reg(REG_PENDING, m_pend, "PENDING");
    if (m_pend == '0) begin
      expect_word("irq_req_o", 0, irq_req);
    end
    while (m_pend != '0) begin
      service_line();
    end
  endtask

  task automatic timer_phase();
    word_t cmp;
    cmp = $urandom % 16;
    axi_write(REG_MASK, 32'h0f);
    m_mask = 5'h0f;
    axi_write(REG_TMR_CMP, cmp);
    repeat (cmp + 3) @(posedge clk);
    check_reg(REG_PENDING, 0, "PENDING");
    axi_write(REG_TMR_CTRL, 32'h1);
    wait_req(cmp + 3);
    m_pend[TIMER_IRQ] = 1'b1;
    check_reg(REG_PENDING, m_pend, "PENDING");
    axi_write(REG_TMR_CTRL, 32'h0);
    service_line();
    repeat (cmp + 3) @(posedge clk);
    check_reg(REG_PENDING, 0, "PENDING");
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h5c37b715));
    errors   = 0;
    checks   = 0;
    m_mask   = '0;
    m_pend   = '0;
    m_active = '0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    irq      = '0;
    irq_ack  = 1'b0;
    wait (rst === 1'b0);
    @(posedge clk);
    for (int it = 0; it < N_ITER; it++) begin
      readback_phase();
      priority_phase();
      timer_phase();
    end
    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o; // 40 ns period
  end

  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- hw/intc_top.sv
`timescale 1ns/1ps

module intc_top (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  intc_pkg::reg_addr_t                s_awaddr_i,
  input  logic                               s_awvalid_i,
  output logic                               s_awready_o,
  input  intc_pkg::word_t                    s_wdata_i,
  input  logic                               s_wvalid_i,
  output logic                               s_wready_o,
  output logic [1:0]                         s_bresp_o,
  output logic                               s_bvalid_o,
  input  logic                               s_bready_i,
  input  intc_pkg::reg_addr_t                s_araddr_i,
  input  logic                               s_arvalid_i,
  output logic                               s_arready_o,
  output intc_pkg::word_t                    s_rdata_o,
  output logic [1:0]                         s_rresp_o,
  output logic                               s_rvalid_o,
  input  logic                               s_rready_i,
  input  logic [intc_pkg::NUM_EXT_IRQ-1:0]   irq_i,
  input  logic                               irq_ack_i,
  output logic                               irq_req_o,
  output intc_pkg::word_t                    vector_offset_o
);
  import intc_pkg::*;

  intc_bus_if bus ();

  irq_vec_t line_req;
  irq_vec_t mask;
  irq_vec_t pending;
  irq_vec_t lowest;
  irq_vec_t active;
  word_t    tmr_cmp;
  logic     tmr_en;
  logic     tick;
  logic     clear_req;
  logic     retire;

  assign line_req[NUM_EXT_IRQ-1:0] = irq_i;
  assign line_req[TIMER_IRQ]       = tick;

  axil_reg_slave u_axil (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .bus         (bus)
  );

  intc_regs u_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus         (bus),
    .pending_i   (pending),
    .active_i    (active),
    .mask_o      (mask),
    .clear_req_o (clear_req),
    .tmr_cmp_o   (tmr_cmp),
    .tmr_en_o    (tmr_en)
  );

  irq_pending u_pending (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .irq_i     (line_req),
    .mask_i    (mask),
    .retire_i  (retire),
    .active_i  (active),
    .pending_o (pending),
    .lowest_o  (lowest)
  );

  irq_sequencer u_seq (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .lowest_i        (lowest),
    .irq_ack_i       (irq_ack_i),
    .clear_req_i     (clear_req),
    .irq_req_o       (irq_req_o),
    .retire_o        (retire),
    .active_o        (active),
    .vector_offset_o (vector_offset_o)
  );

  irq_timer u_timer (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .en_i   (tmr_en),
    .cmp_i  (tmr_cmp),
    .tick_o (tick)
  );

endmodule

//--- hw/irq_timer.sv
`timescale 1ns/1ps

module irq_timer (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            en_i,
  input  intc_pkg::word_t cmp_i,
  output logic            tick_o
);
  import intc_pkg::*;

  word_t cnt_q;
  logic  hit;

  assign hit = (cnt_q == cmp_i);

  // period is cmp_i + 1 cycles since the match cycle restarts at zero
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (!en_i) begin
      cnt_q <= '0; // held while disabled
    end else if (hit) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + word_t'(1);
    end
  end

  assign tick_o = en_i & hit;

endmodule

//--- hw/irq_sequencer.sv
`timescale 1ns/1ps

module irq_sequencer (
  input  logic               clk_i,
  input  logic               rst_i,
  input  intc_pkg::irq_vec_t lowest_i,
  input  logic               irq_ack_i,
  input  logic               clear_req_i,
  output logic               irq_req_o,
  output logic               retire_o,
  output intc_pkg::irq_vec_t active_o,
  output intc_pkg::word_t    vector_offset_o
);
  import intc_pkg::*;

  seq_state_t state_q;
  irq_vec_t   active_q;
  word_t      offset;
  logic       retire;

  // a clear outside of service is dropped here and nowhere else
  assign retire = (state_q == SEQ_SERVICE) & clear_req_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= SEQ_IDLE;
      active_q <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          if (|lowest_i) begin
            active_q <= lowest_i;
            state_q  <= SEQ_DISPATCH;
          end
        end
        SEQ_DISPATCH: begin
          if (irq_ack_i) begin
            state_q <= SEQ_SERVICE;
          end
        end
        SEQ_SERVICE: begin
          if (retire) begin
            active_q <= '0;
            state_q  <= SEQ_IDLE;
          end
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

  // one-hot to byte offset, four bytes per vector slot
  always_comb begin
    offset = '0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      if (active_q[i]) begin
        offset = word_t'(i) << 2;
      end
    end
  end

  assign irq_req_o       = (state_q == SEQ_DISPATCH);
  assign retire_o        = retire;
  assign active_o        = active_q;
  assign vector_offset_o = offset;

endmodule

//--- hw/irq_pending.sv
`timescale 1ns/1ps

module irq_pending (
  input  logic               clk_i,
  input  logic               rst_i,
  input  intc_pkg::irq_vec_t irq_i,
  input  intc_pkg::irq_vec_t mask_i,
  input  logic               retire_i,
  input  intc_pkg::irq_vec_t active_i,
  output intc_pkg::irq_vec_t pending_o,
  output intc_pkg::irq_vec_t lowest_o
);
  import intc_pkg::*;

  irq_vec_t pending_q;
  irq_vec_t kept;
  irq_vec_t lowest;
  logic     seen;

  // masking only gates new requests, bits already pending stay
  assign kept = retire_i ? (pending_q & ~active_i) : pending_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= kept | (irq_i & ~mask_i);
    end
  end

  // priority chain, line 0 is the most urgent
  always_comb begin
    seen   = 1'b0;
    lowest = '0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      lowest[i] = pending_q[i] & ~seen;
      seen      = seen | pending_q[i];
    end
  end

  assign pending_o = pending_q;
  assign lowest_o  = lowest;

endmodule

//--- hw/intc_regs.sv
`timescale 1ns/1ps

module intc_regs (
  input  logic               clk_i,
  input  logic               rst_i,
  intc_bus_if.slave          bus,
  input  intc_pkg::irq_vec_t pending_i,
  input  intc_pkg::irq_vec_t active_i,
  output intc_pkg::irq_vec_t mask_o,
  output logic               clear_req_o,
  output intc_pkg::word_t    tmr_cmp_o,
  output logic               tmr_en_o
);
  import intc_pkg::*;

  irq_vec_t mask_q;
  word_t    tmr_cmp_q;
  logic     tmr_en_q;
  logic     clear_req_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_q      <= '0;
      tmr_cmp_q   <= '0;
      tmr_en_q    <= 1'b0;
      clear_req_q <= 1'b0;
    end else begin
      clear_req_q <= 1'b0;
      if (bus.wr_en) begin
        case (bus.addr)
          REG_MASK: begin
            mask_q <= bus.wdata[NUM_IRQ-1:0];
          end
          REG_CLEAR: begin
            clear_req_q <= 1'b1; // the written value is not looked at
          end
          REG_TMR_CMP: begin
            tmr_cmp_q <= bus.wdata;
          end
          REG_TMR_CTRL: begin
            tmr_en_q <= bus.wdata[0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    if (bus.rd_en) begin
      case (bus.addr)
        REG_MASK:     bus.rdata = word_t'(mask_q);
        REG_PENDING:  bus.rdata = word_t'(pending_i);
        REG_ACTIVE:   bus.rdata = word_t'(active_i);
        REG_TMR_CMP:  bus.rdata = tmr_cmp_q;
        REG_TMR_CTRL: bus.rdata = word_t'(tmr_en_q);
        default:      bus.rdata = '0; // CLEAR and unmapped offsets read zero
      endcase
    end
  end

  assign mask_o      = mask_q;
  assign clear_req_o = clear_req_q;
  assign tmr_cmp_o   = tmr_cmp_q;
  assign tmr_en_o    = tmr_en_q;

endmodule

//--- hw/axil_reg_slave.sv
`timescale 1ns/1ps

module axil_reg_slave (
  input  logic               clk_i,
  input  logic               rst_i,
  input  intc_pkg::reg_addr_t s_awaddr_i,
  input  logic               s_awvalid_i,
  output logic               s_awready_o,
  input  intc_pkg::word_t    s_wdata_i,
  input  logic               s_wvalid_i,
  output logic               s_wready_o,
  output logic [1:0]         s_bresp_o,
  output logic               s_bvalid_o,
  input  logic               s_bready_i,
  input  intc_pkg::reg_addr_t s_araddr_i,
  input  logic               s_arvalid_i,
  output logic               s_arready_o,
  output intc_pkg::word_t    s_rdata_o,
  output logic [1:0]         s_rresp_o,
  output logic               s_rvalid_o,
  input  logic               s_rready_i,
  intc_bus_if.master         bus
);
  import intc_pkg::*;

  logic  aw_ready_q; // drives both AWREADY and WREADY
  logic  ar_ready_q;
  logic  bvalid_q;
  logic  rvalid_q;
  word_t rdata_q;
  logic  rd_start;
  logic  wr_start;

  // only one ready is ever high, so the request bus carries a single access
  assign rd_start = s_arvalid_i & ~ar_ready_q & ~rvalid_q & ~aw_ready_q;
  assign wr_start = s_awvalid_i & s_wvalid_i & ~aw_ready_q & ~bvalid_q
                  & ~ar_ready_q & ~rd_start; // reads win a tie

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_ready_q <= 1'b0;
      ar_ready_q <= 1'b0;
      bvalid_q   <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      aw_ready_q <= wr_start; // ready lasts exactly one cycle
      ar_ready_q <= rd_start;

      if (bus.wr_en) begin
        bvalid_q <= 1'b1;
      end else if (s_bready_i) begin
        bvalid_q <= 1'b0;
      end

      if (bus.rd_en) begin
        rvalid_q <= 1'b1;
      end else if (s_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // read data is held for the R channel until RREADY
  always_ff @(posedge clk_i) begin
    if (bus.rd_en) begin
      rdata_q <= bus.rdata;
    end
  end

  assign bus.wr_en = aw_ready_q & s_awvalid_i & s_wvalid_i;
  assign bus.rd_en = ar_ready_q & s_arvalid_i;
  assign bus.addr  = aw_ready_q ? s_awaddr_i : s_araddr_i;
  assign bus.wdata = s_wdata_i;

  assign s_awready_o = aw_ready_q;
  assign s_wready_o  = aw_ready_q;
  assign s_arready_o = ar_ready_q;
  assign s_bvalid_o  = bvalid_q;
  assign s_bresp_o   = 2'b00; // always OKAY
  assign s_rvalid_o  = rvalid_q;
  assign s_rdata_o   = rdata_q;
  assign s_rresp_o   = 2'b00;

endmodule

//--- hw/intc_bus_if.sv
`timescale 1ns/1ps

interface intc_bus_if;
  import intc_pkg::*;

  logic      wr_en; // one-cycle write strobe
  logic      rd_en; // one-cycle read strobe
  reg_addr_t addr;
  word_t     wdata;
  word_t     rdata; // combinational from addr while rd_en is high

  modport master (
    output wr_en,
    output rd_en,
    output addr,
    output wdata,
    input  rdata
  );

  modport slave (
    input  wr_en,
    input  rd_en,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

//--- hw/intc_pkg.sv
package intc_pkg;

  localparam int NUM_IRQ     = 5;
  localparam int NUM_EXT_IRQ = 4;
  localparam int TIMER_IRQ   = 4; // timer sits above the external lines
  localparam int XLEN        = 32;
  localparam int ADDR_W      = 5;

  typedef logic [NUM_IRQ-1:0] irq_vec_t;
  typedef logic [XLEN-1:0]    word_t;
  typedef logic [ADDR_W-1:0]  reg_addr_t;

  localparam reg_addr_t REG_MASK     = 5'h00;
  localparam reg_addr_t REG_PENDING  = 5'h04;
  localparam reg_addr_t REG_ACTIVE   = 5'h08;
  localparam reg_addr_t REG_CLEAR    = 5'h0C;
  localparam reg_addr_t REG_TMR_CMP  = 5'h10;
  localparam reg_addr_t REG_TMR_CTRL = 5'h14;

  // dispatch holds the request to the core until it takes the trap
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_DISPATCH,
    SEQ_SERVICE
  } seq_state_t;

endpackage
